// ==== common/adc_acq_defs.svh ====
`ifndef ADC_ACQ_DEFS_SVH
`define ADC_ACQ_DEFS_SVH

////////////////////////////////////////
// sample and buffer geometry
////////////////////////////////////////

`define SAMPLE_W          12              // one adc sample
`define ENTRY_W           26              // two samples plus two over-range bits
`define CBUF_AW           10              // 1024 entry circular buffer
`define TFIFO_AW          3               // 8 trigger addresses in flight

////////////////////////////////////////
// output word format
////////////////////////////////////////

`define ENTRIES_PER_WORD  4               // entries packed into one data word
`define OUT_W             132             // tag plus payload
`define TAG_W             4
`define PAYLOAD_W         128

// word tags, top nibble of out_data
`define TAG_HDR           4'd1
`define TAG_DAT           4'd2
`define TAG_CSUM          4'd3

// credits held after reset
`define OUT_CREDITS       4

`endif

// ==== common/adc_acq_pkg.sv ====
`default_nettype none

`include "adc_acq_defs.svh"

package adc_acq_pkg;

    ////////////////////////////////////////
    // buffer side types
    ////////////////////////////////////////

    // bit 0 ovr a, 12:1 sample a, 13 ovr b, 25:14 sample b
    typedef logic [`ENTRY_W-1:0] entry_t;

    typedef logic [`CBUF_AW-1:0] cbuf_addr_t;    // wraps modulo buffer depth

    ////////////////////////////////////////
    // output side types
    ////////////////////////////////////////

    // 131:128 tag, 127:0 payload
    typedef logic [`OUT_W-1:0] out_word_t;

    // which word readout asks the assembler for
    typedef enum logic [1:0] {
        WK_HDR,     // waveform header
        WK_DAT,     // four buffer entries
        WK_CSUM     // xor of the data payloads
    } word_kind_e;

endpackage

`default_nettype wire

// ==== capture/sample_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module sample_capture import adc_acq_pkg::*; (
    input  wire         adc_clk,
    input  wire         rst_n,
    input  wire entry_t sample_in,
    input  wire         acq_enable,
    input  wire         acq_trig,
    input  wire         use_dummy,
    output logic        wr_en,        // write strobe, one cycle after sampling
    output cbuf_addr_t  wr_addr,
    output entry_t      wr_data,
    output logic        trig_push,    // queue this entry's address
    output cbuf_addr_t  trig_addr
);

    logic [`SAMPLE_W-1:0] dummy_cnt;   // free running test pattern
    entry_t               dummy_entry;

    // both samples carry the counter, over-range bits held low
    assign dummy_entry = {dummy_cnt, 1'b0, dummy_cnt, 1'b0};

    ////////////////////////////////////////
    // strobes and counters
    ////////////////////////////////////////

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en     <= 1'b0;
            trig_push <= 1'b0;
            dummy_cnt <= '0;
            wr_addr   <= '0;
        end else begin
            wr_en     <= acq_enable;
            trig_push <= acq_enable & acq_trig;   // triggers ignored while disabled
            if (acq_enable)
                dummy_cnt <= dummy_cnt + 1'b1;    // counts every entry, either source
            if (wr_en)
                wr_addr <= wr_addr + 1'b1;        // step past the entry just written, wraps
        end
    end

    // sampled entry, no reset needed
    always_ff @(posedge adc_clk) begin
        if (acq_enable)
            wr_data <= use_dummy ? dummy_entry : sample_in;
    end

    // the pushed address is the slot this same entry lands in
    assign trig_addr = wr_addr;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a trigger address must always point at a slot that is being filled
    a_push_with_write : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        trig_push |-> wr_en
    );

endmodule

`default_nettype wire

// ==== capture/circ_buf_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module circ_buf_ram (
    input  wire                  adc_clk,
    input  wire                  wr_en,
    input  wire [`CBUF_AW-1:0]   wr_addr,
    input  wire [`ENTRY_W-1:0]   wr_data,
    input  wire                  rd_en,
    input  wire [`CBUF_AW-1:0]   rd_addr,
    output logic [`ENTRY_W-1:0]  rd_data    // valid the cycle after rd_en
);

    localparam int DEPTH = 1 << `CBUF_AW;

    logic [`ENTRY_W-1:0] mem [0:DEPTH-1];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;   // oldest entry overwritten on wrap
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // registered read, holds last value when idle
    always_ff @(posedge adc_clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/trig_addr_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module trig_addr_fifo import adc_acq_pkg::*; (
    input  wire             adc_clk,
    input  wire             rst_n,
    input  wire             push,
    input  wire cbuf_addr_t push_data,
    input  wire             pop,
    output cbuf_addr_t      head,       // first word falls through
    output logic            empty,
    output logic            full
);

    localparam int DEPTH = 1 << `TFIFO_AW;

    cbuf_addr_t         mem [0:DEPTH-1];
    logic [`TFIFO_AW:0] wr_ptr;         // extra msb tells full from empty
    logic [`TFIFO_AW:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`TFIFO_AW] != rd_ptr[`TFIFO_AW]) &&
                   (wr_ptr[`TFIFO_AW-1:0] == rd_ptr[`TFIFO_AW-1:0]);

    assign head = mem[rd_ptr[`TFIFO_AW-1:0]];

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (push && !full)
            mem[wr_ptr[`TFIFO_AW-1:0]] <= push_data;   // push on full is lost
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // readout has to look at empty before popping
    a_no_pop_empty : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        pop |-> !empty
    );

endmodule

`default_nettype wire

// ==== readout/readout_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module readout_ctrl import adc_acq_pkg::*; (
    input  wire             adc_clk,
    input  wire             rst_n,
    input  wire             fifo_empty,
    input  wire cbuf_addr_t fifo_head,
    input  wire [13:0]      num_bursts,
    input  wire [15:0]      pre_trig,
    input  wire             out_credit,
    output logic            fifo_pop,       // take one trigger address
    output logic            rd_en,
    output cbuf_addr_t      rd_addr,
    output logic            shift_en,       // ram data valid, shift into window
    output logic            emit,           // assembler registers a word
    output word_kind_e      kind,
    output cbuf_addr_t      trig_addr_hdr,
    output logic            acq_busy
);

    localparam int FCNT_W = $clog2(`ENTRIES_PER_WORD);
    localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

    typedef enum logic [2:0] {S_IDLE, S_HEADER, S_FETCH, S_DATA, S_CSUM} state_t;

    state_t             state, state_nxt;
    logic [13:0]        burst_cnt;          // data words still to send
    logic [FCNT_W-1:0]  fetch_cnt;          // reads done for this word
    logic [CRED_W-1:0]  credit_cnt;
    logic               credit_ok;
    cbuf_addr_t         start_addr;

    assign credit_ok  = (credit_cnt != '0);
    assign start_addr = fifo_head - cbuf_addr_t'(pre_trig[`CBUF_AW-1:0]);  // mod depth
    assign acq_busy   = (state != S_IDLE);

    ////////////////////////////////////////
    // next state and strobes
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        fifo_pop  = 1'b0;
        rd_en     = 1'b0;
        emit      = 1'b0;
        kind      = WK_DAT;
        case (state)
            S_IDLE: begin
                if (!fifo_empty) begin
                    fifo_pop  = 1'b1;
                    state_nxt = S_HEADER;
                end
            end
            S_HEADER: begin
                kind = WK_HDR;
                if (credit_ok) begin
                    emit      = 1'b1;
                    state_nxt = (burst_cnt == '0) ? S_CSUM : S_FETCH;
                end
            end
            S_FETCH: begin
                rd_en = 1'b1;
                if (fetch_cnt == FCNT_W'(`ENTRIES_PER_WORD - 1))
                    state_nxt = S_DATA;
            end
            S_DATA: begin
                // wait for the last entry to land in the window
                if (!shift_en && credit_ok) begin
                    emit      = 1'b1;
                    state_nxt = (burst_cnt == 14'd1) ? S_CSUM : S_FETCH;
                end
            end
            S_CSUM: begin
                kind = WK_CSUM;
                if (credit_ok) begin
                    emit      = 1'b1;
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // state, counters, read address
    ////////////////////////////////////////

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rd_addr   <= '0;
            burst_cnt <= '0;
            fetch_cnt <= '0;
            shift_en  <= 1'b0;
        end else begin
            state    <= state_nxt;
            shift_en <= rd_en;                      // ram read latency of one
            if (fifo_pop) begin
                rd_addr   <= start_addr;
                burst_cnt <= num_bursts;
            end else if (rd_en) begin
                rd_addr   <= rd_addr + 1'b1;        // wraps with the buffer
                fetch_cnt <= fetch_cnt + 1'b1;      // wraps after the fourth read
            end
            if (emit && state == S_DATA)
                burst_cnt <= burst_cnt - 1'b1;
        end
    end

    // header field, follows the popped address
    always_ff @(posedge adc_clk) begin
        if (fifo_pop)
            trig_addr_hdr <= fifo_head;
    end

    // credit counter, spent at emit and returned by the sink
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n)
            credit_cnt <= CRED_W'(`OUT_CREDITS);
        else if (emit && !out_credit)
            credit_cnt <= credit_cnt - 1'b1;
        else if (out_credit && !emit)
            credit_cnt <= credit_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // sink must not return more credits than it was given
    a_credit_max : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        credit_cnt <= CRED_W'(`OUT_CREDITS)
    );

    a_emit_credit : assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        emit |-> credit_cnt != '0
    );

endmodule

`default_nettype wire

// ==== readout/word_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module word_assembler import adc_acq_pkg::*; (
    input  wire             adc_clk,
    input  wire             rst_n,
    input  wire entry_t     rd_data,
    input  wire             shift_en,
    input  wire             emit,
    input  wire word_kind_e kind,
    input  wire cbuf_addr_t trig_addr_hdr,
    input  wire [11:0]      channel_tag,
    input  wire [13:0]      num_bursts,
    input  wire [15:0]      pre_trig,
    output out_word_t       out_data,
    output logic            out_valid
);

    localparam int WIN_W   = `ENTRIES_PER_WORD * `ENTRY_W;
    localparam int DAT_PAD = `PAYLOAD_W - WIN_W;          // unused top of a data word
    localparam int HDR_PAD = `PAYLOAD_W - 70;             // header fields take 70 bits

    entry_t [`ENTRIES_PER_WORD-1:0] win;   // entry 0 is the oldest
    logic [`PAYLOAD_W-1:0]          dat_payload;
    logic [`PAYLOAD_W-1:0]          hdr_payload;
    logic [`PAYLOAD_W-1:0]          csum;
    logic [`PAYLOAD_W-1:0]          payload;
    logic [`TAG_W-1:0]              tag;
    logic [11:0]                    wfm_num;

    // new entries enter at the top and age downward
    always_ff @(posedge adc_clk) begin
        if (shift_en)
            win <= {rd_data, win[`ENTRIES_PER_WORD-1:1]};
    end

    assign dat_payload = {{DAT_PAD{1'b0}}, win};

    // chan tag, wfm number, trig addr padded to 16, bursts, pre trig
    assign hdr_payload = {{HDR_PAD{1'b0}}, pre_trig, num_bursts,
                          {(16 - `CBUF_AW){1'b0}}, trig_addr_hdr, wfm_num, channel_tag};

    ////////////////////////////////////////
    // word select
    ////////////////////////////////////////

    always_comb begin
        case (kind)
            WK_HDR:  begin tag = `TAG_HDR;  payload = hdr_payload; end
            WK_CSUM: begin tag = `TAG_CSUM; payload = csum;        end
            default: begin tag = `TAG_DAT;  payload = dat_payload; end
        endcase
    end

    // running xor, restarted by every header
    always_ff @(posedge adc_clk) begin
        if (emit && kind == WK_HDR)
            csum <= '0;
        else if (emit && kind == WK_DAT)
            csum <= csum ^ dat_payload;
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wfm_num   <= '0;
        end else begin
            out_valid <= emit;
            if (emit && kind == WK_CSUM)
                wfm_num <= wfm_num + 1'b1;    // next waveform
        end
    end

    // output word register
    always_ff @(posedge adc_clk) begin
        if (emit)
            out_data <= {tag, payload};
    end

endmodule

`default_nettype wire

// ==== verilog/adc_acq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_acq_top (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  wire adc_acq_pkg::entry_t   sample_in,     // packed sample pair
    input  wire                        acq_enable,    // write into the buffer
    input  wire                        acq_trig,      // mark current write address
    input  wire                        use_dummy,     // counter instead of sample_in
    input  wire [11:0]                 channel_tag,
    input  wire [13:0]                 num_bursts,    // data words per waveform
    input  wire [15:0]                 pre_trig,      // entries before the trigger
    input  wire                        out_credit,    // one credit back per cycle
    output adc_acq_pkg::out_word_t     out_data,
    output logic                       out_valid,
    output logic                       acq_busy       // readout in progress
);

    ////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////

    logic                     wr_en;
    adc_acq_pkg::cbuf_addr_t  wr_addr;
    adc_acq_pkg::entry_t      wr_data;
    logic                     trig_push;
    adc_acq_pkg::cbuf_addr_t  trig_addr;
    logic                     rd_en;
    adc_acq_pkg::cbuf_addr_t  rd_addr;
    adc_acq_pkg::entry_t      rd_data;
    adc_acq_pkg::cbuf_addr_t  fifo_head;
    logic                     fifo_empty;
    logic                     fifo_pop;
    logic                     shift_en;
    logic                     emit;
    adc_acq_pkg::word_kind_e  kind;
    adc_acq_pkg::cbuf_addr_t  trig_addr_hdr;

    ////////////////////////////////////////
    // capture side
    ////////////////////////////////////////

    sample_capture u_capture (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .sample_in  (sample_in),
        .acq_enable (acq_enable),
        .acq_trig   (acq_trig),
        .use_dummy  (use_dummy),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .trig_push  (trig_push),
        .trig_addr  (trig_addr)
    );

    circ_buf_ram u_cbuf (
        .adc_clk (adc_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////////////////////////
    // trigger queue and readout
    ////////////////////////////////////////

    trig_addr_fifo u_tfifo (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .push      (trig_push),
        .push_data (trig_addr),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      ()                 // overflow drops inside the fifo
    );

    readout_ctrl u_readout (
        .adc_clk       (adc_clk),
        .rst_n         (rst_n),
        .fifo_empty    (fifo_empty),
        .fifo_head     (fifo_head),
        .num_bursts    (num_bursts),
        .pre_trig      (pre_trig),
        .out_credit    (out_credit),
        .fifo_pop      (fifo_pop),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .shift_en      (shift_en),
        .emit          (emit),
        .kind          (kind),
        .trig_addr_hdr (trig_addr_hdr),
        .acq_busy      (acq_busy)
    );

    word_assembler u_assembler (
        .adc_clk       (adc_clk),
        .rst_n         (rst_n),
        .rd_data       (rd_data),
        .shift_en      (shift_en),
        .emit          (emit),
        .kind          (kind),
        .trig_addr_hdr (trig_addr_hdr),
        .channel_tag   (channel_tag),
        .num_bursts    (num_bursts),
        .pre_trig      (pre_trig),
        .out_data      (out_data),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

// ==== verification/acq_model.svh ====
`ifndef ACQ_MODEL_SVH
`define ACQ_MODEL_SVH

////////////////////////////////////////
// shadow buffer
////////////////////////////////////////

localparam int CBUF_DEPTH = 1 << `CBUF_AW;

logic [`ENTRY_W-1:0]  shadow [0:CBUF_DEPTH-1];
int unsigned          wr_ptr_m  = 0;    // slot the next enabled sample lands in
logic [`SAMPLE_W-1:0] dummy_m   = '0;   // mirrors the capture test counter
int unsigned          wfm_m     = 0;    // waveform number, low 12 bits go out

// triggers still waiting for the tail of their window
int unsigned pend_addr[$];
int unsigned pend_nb[$];
int unsigned pend_pt[$];
int unsigned pend_chan[$];
int          pend_left[$];              // writes missing before the window is complete

logic [`OUT_W-1:0] exp_q[$];            // expected words in output order
int unsigned       exp_total = 0;       // words owed over the whole run

// counter on both samples, over-range bits low
function automatic logic [`ENTRY_W-1:0] dummy_entry(input logic [`SAMPLE_W-1:0] cnt);
    return {cnt, 1'b0, cnt, 1'b0};
endfunction

// header, data words from the pre-trigger window, then the xor word
task automatic build_waveform(input int unsigned addr, input int unsigned nb,
                              input int unsigned pt, input int unsigned chan);
    logic [`PAYLOAD_W-1:0] payload;
    logic [`PAYLOAD_W-1:0] csum;
    int unsigned           start;
    payload        = '0;
    payload[11:0]  = chan[11:0];
    payload[23:12] = wfm_m[11:0];
    payload[39:24] = addr[15:0];        // 10 bit address, zero padded
    payload[53:40] = nb[13:0];
    payload[69:54] = pt[15:0];
    exp_q.push_back({`TAG_HDR, payload});
    csum  = '0;
    start = (addr + CBUF_DEPTH - (pt % CBUF_DEPTH)) % CBUF_DEPTH;
    for (int b = 0; b < nb; b++) begin
        payload = '0;
        for (int k = 0; k < `ENTRIES_PER_WORD; k++)
            payload[26*k +: 26] = shadow[(start + 4*b + k) % CBUF_DEPTH];   // oldest low
        csum ^= payload;
        exp_q.push_back({`TAG_DAT, payload});
    end
    exp_q.push_back({`TAG_CSUM, csum});
    wfm_m++;
endtask

// one enabled sample, called with the values driven this cycle
task automatic model_write(input logic trg, input logic dum, input logic [`ENTRY_W-1:0] smp,
                           input int unsigned nb, input int unsigned pt,
                           input int unsigned chan);
    int          need;
    int unsigned a;
    int unsigned n;
    int unsigned p;
    int unsigned ch;
    shadow[wr_ptr_m] = dum ? dummy_entry(dummy_m) : smp;
    if (trg) begin
        need = 4 * int'(nb) - int'(pt);    // entries from the trigger slot onward
        if (need < 1)
            need = 1;
        pend_addr.push_back(wr_ptr_m);
        pend_nb.push_back(nb);
        pend_pt.push_back(pt);
        pend_chan.push_back(chan);
        pend_left.push_back(need);
        exp_total += nb + 2;
    end
    foreach (pend_left[i])
        if (pend_left[i] > 0)
            pend_left[i]--;
    while (pend_left.size() > 0 && pend_left[0] <= 0) begin
        a  = pend_addr.pop_front();
        n  = pend_nb.pop_front();
        p  = pend_pt.pop_front();
        ch = pend_chan.pop_front();
        void'(pend_left.pop_front());
        build_waveform(a, n, p, ch);
    end
    wr_ptr_m = (wr_ptr_m + 1) % CBUF_DEPTH;
    dummy_m  = dummy_m + 1'b1;             // counts every entry, either source
endtask

`endif

// ==== verification/tb_adc_acq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "adc_acq_defs.svh"

module tb_adc_acq;

    localparam int NUM_TRIG    = 16;
    localparam int WRAP_IDX    = 3;     // this trigger is placed just past the buffer end
    localparam int WRAP_SLOT   = 8;
    localparam int DISABLE_IDX = 5;     // acquisition paused in the gap after this one

    logic                  adc_clk;
    logic                  rst_n;
    logic [`ENTRY_W-1:0]   sample_in;
    logic                  acq_enable;
    logic                  acq_trig;
    logic                  use_dummy;
    logic [11:0]           channel_tag;
    logic [13:0]           num_bursts;
    logic [15:0]           pre_trig;
    logic                  out_credit;
    logic [`OUT_W-1:0]     out_data;
    logic                  out_valid;
    logic                  acq_busy;

    logic [31:0]       stim_state   = 32'd82657;
    logic [31:0]       credit_state = 32'd82657;
    int                word_errs    = 0;
    int                credit_errs  = 0;
    int                count_errs   = 0;
    int                tb_credits   = `OUT_CREDITS;   // mirror of the dut credit counter
    int unsigned       obs_count    = 0;
    int unsigned       cmp_count    = 0;
    logic [`OUT_W-1:0] obs_q[$];                      // words seen, not yet compared

    `include "acq_model.svh"

    adc_acq_top u_dut (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .sample_in   (sample_in),
        .acq_enable  (acq_enable),
        .acq_trig    (acq_trig),
        .use_dummy   (use_dummy),
        .channel_tag (channel_tag),
        .num_bursts  (num_bursts),
        .pre_trig    (pre_trig),
        .out_credit  (out_credit),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .acq_busy    (acq_busy)
    );

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] st);
        return st * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned draw_stim(input int unsigned n);
        stim_state = lcg_step(stim_state);
        return (stim_state >> 8) % n;
    endfunction

    function automatic int unsigned draw_delay(input int unsigned n);
        credit_state = lcg_step(credit_state);   // own stream for the sink side
        return (credit_state >> 8) % n;
    endfunction

    // new sample pair, and the model sees what the dut samples next edge
    task automatic drive_inputs(input logic en, input logic trg);
        logic [`ENTRY_W-1:0] smp;
        stim_state = lcg_step(stim_state);
        smp        = stim_state[31:6];
        sample_in  = smp;
        acq_enable = en;
        acq_trig   = trg;
        if (en)
            model_write(trg, use_dummy, smp, num_bursts, pre_trig, channel_tag);
    endtask

    task automatic compare_words();
        logic [`OUT_W-1:0] exp_w;
        logic [`OUT_W-1:0] obs_w;
        while (exp_q.size() > 0 && obs_q.size() > 0) begin
            exp_w = exp_q.pop_front();
            obs_w = obs_q.pop_front();
            assert (obs_w === exp_w) else begin
                $display("[ERROR] out_data word %0d: expected %h, got %h",
                         cmp_count, exp_w, obs_w);
                word_errs++;
            end
            cmp_count++;
        end
    endtask

    initial begin
        adc_clk = 1'b0;
        forever #2 adc_clk = ~adc_clk;   // 4 ns period
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        int   gap;
        logic en;
        logic trg;
        rst_n       = 1'b0;
        sample_in   = '0;
        acq_enable  = 1'b0;
        acq_trig    = 1'b0;
        use_dummy   = 1'b0;
        channel_tag = '0;
        num_bursts  = 14'd1;
        pre_trig    = '0;
        repeat (8) @(posedge adc_clk);
        @(negedge adc_clk);
        rst_n = 1'b1;
        assert (out_valid === 1'b0 && acq_busy === 1'b0) else begin
            $display("[ERROR] out_valid/acq_busy after reset: expected 0/0, got %h/%h",
                     out_valid, acq_busy);
            word_errs++;
        end
        repeat (100) begin              // fill the pre-trigger history
            @(negedge adc_clk);
            drive_inputs(1'b1, 1'b0);
        end
        for (int i = 0; i < NUM_TRIG; i++) begin
            if (i == WRAP_IDX) begin
                while (wr_ptr_m != WRAP_SLOT) begin
                    @(negedge adc_clk);
                    drive_inputs(1'b1, 1'b0);
                end
            end
            @(negedge adc_clk);
            num_bursts  = 14'(1 + draw_stim(15));
            pre_trig    = 16'((i == WRAP_IDX) ? 40 + draw_stim(21) : draw_stim(61));
            channel_tag = 12'(draw_stim(4096));
            drive_inputs(1'b1, 1'b1);
            gap = 300 + draw_stim(101);
            for (int c = 0; c < gap; c++) begin
                @(negedge adc_clk);
                if (c == 150)
                    use_dummy = (i % 4 == 2) || (draw_stim(3) == 0);   // source for next trigger
                en  = !(i == DISABLE_IDX && c >= 150 && c < 200);
                trg = !en && (c % 10 == 5);     // must be ignored
                drive_inputs(en, trg);
            end
        end
        @(negedge adc_clk);
        acq_enable = 1'b0;
        wait (obs_count == exp_total && acq_busy == 1'b0);
        repeat (20) @(negedge adc_clk);        // room for stray words
        compare_words();
        assert (obs_count == exp_total) else begin
            $display("[ERROR] word count: expected %h, got %h", exp_total, obs_count);
            count_errs++;
        end
        assert (exp_q.size() == 0 && obs_q.size() == 0 && pend_left.size() == 0) else begin
            $display("words left over: %0d expected and %0d seen were never matched",
                     exp_q.size(), obs_q.size());
            count_errs++;
        end
        $display("error counts: %0d word, %0d credit, %0d count",
                 word_errs, credit_errs, count_errs);
        if (word_errs + credit_errs + count_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // output monitor and credit return
    ////////////////////////////////////////

    initial begin : monitor
        int unsigned due_q[$];           // cycle at which each credit goes back
        int unsigned due;
        int unsigned last_due;
        int unsigned cyc;
        logic        credit_drv;
        last_due   = 0;
        cyc        = 0;
        credit_drv = 1'b0;
        out_credit = 1'b0;
        forever begin
            @(negedge adc_clk);
            cyc++;
            if (out_valid) begin
                assert (tb_credits > 0) else begin
                    $display("out_valid rose with no credits left at %0t", $time);
                    credit_errs++;
                end
                obs_q.push_back(out_data);
                obs_count++;
                due = cyc + draw_delay(6);
                if (due < last_due)
                    due = last_due;      // credits go back in order
                last_due = due;
                due_q.push_back(due);
            end
            tb_credits = tb_credits + int'(credit_drv) - int'(out_valid);
            credit_drv = (due_q.size() > 0 && due_q[0] <= cyc);   // one per cycle at most
            if (credit_drv)
                void'(due_q.pop_front());
            out_credit = credit_drv;
            compare_words();
        end
    end

    // watchdog
    initial begin
        repeat (NUM_TRIG * 500) @(posedge adc_clk);
        $display("timeout: run did not finish within %0d cycles", NUM_TRIG * 500);
        $display("error counts: %0d word, %0d credit, %0d count",
                 word_errs, credit_errs, count_errs);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
+incdir+verification
common/adc_acq_pkg.sv
capture/sample_capture.sv
capture/circ_buf_ram.sv
verilog/trig_addr_fifo.sv
readout/readout_ctrl.sv
readout/word_assembler.sv
verilog/adc_acq_top.sv
verification/tb_adc_acq.sv
